// File: rtl/pingpong_pkg.sv
`default_nettype none

package pingpong_pkg;

    localparam int unsigned count_w      = 4;
    localparam int unsigned prescale_w   = 16;
    localparam int unsigned scan_div     = 4;  // Clocks per displayed digit
    localparam int unsigned debounce_len = 4;

    localparam logic [7:0] addr_ctrl     = 8'h00;
    localparam logic [7:0] addr_bounds   = 8'h04;
    localparam logic [7:0] addr_prescale = 8'h08;
    localparam logic [7:0] addr_status   = 8'h0C;

    localparam int unsigned ctrl_run_bit     = 0;
    localparam int unsigned ctrl_restart_bit = 1;
    localparam int unsigned bounds_min_lsb   = 0;
    localparam int unsigned bounds_max_lsb   = 8;

    // Active low, segment a in the msb, dp in the lsb
    typedef logic [7:0] seg_t;

    localparam seg_t digit_glyph [10] = '{
        8'b00000011, 8'b10011111, 8'b00100101, 8'b00001101, 8'b10011001,
        8'b01001001, 8'b01000001, 8'b00011111, 8'b00000001, 8'b00001001
    };

    localparam seg_t glyph_up   = 8'b00111011;
    localparam seg_t glyph_down = 8'b11000111;

endpackage

`default_nettype wire

// File: rtl/ctr_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ctr_if;

    logic                                 run;
    logic                                 restart;  // One-cycle pulse
    logic [pingpong_pkg::count_w-1:0]     min_val;
    logic [pingpong_pkg::count_w-1:0]     max_val;
    logic [pingpong_pkg::prescale_w-1:0]  prescale;
    logic [pingpong_pkg::count_w-1:0]     count;
    logic                                 direction;  // 1 is up

    modport regs (output run, restart, min_val, max_val, prescale,
                  input count, direction);
    modport counter (input run, restart, min_val, max_val, prescale,
                     output count, direction);
    modport display (input count, direction);

endinterface

`default_nettype wire

// File: rtl/apb_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module apb_ctrl_regs (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [7:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    ctr_if.regs              cfg
);

    logic wr_en;
    logic addr_hit;

    assign wr_en  = psel & penable & pwrite;  // Access phase, no wait states
    assign pready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            cfg.run      <= 1'b0;
            cfg.restart  <= 1'b0;
            cfg.min_val  <= '0;
            cfg.max_val  <= '1;
            cfg.prescale <= '0;
        end else begin
            cfg.restart <= wr_en && (paddr == pingpong_pkg::addr_ctrl)
                           && pwdata[pingpong_pkg::ctrl_restart_bit];
            if (wr_en) begin
                case (paddr)
                    pingpong_pkg::addr_ctrl:
                        cfg.run <= pwdata[pingpong_pkg::ctrl_run_bit];
                    pingpong_pkg::addr_bounds: begin
                        cfg.min_val <= pwdata[pingpong_pkg::bounds_min_lsb +: pingpong_pkg::count_w];
                        cfg.max_val <= pwdata[pingpong_pkg::bounds_max_lsb +: pingpong_pkg::count_w];
                    end
                    pingpong_pkg::addr_prescale:
                        cfg.prescale <= pwdata[pingpong_pkg::prescale_w-1:0];
                    default: ;  // STATUS and unknown addresses ignore writes
                endcase
            end
        end
    end

    // Read data and address decode
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            pingpong_pkg::addr_ctrl:
                prdata[pingpong_pkg::ctrl_run_bit] = cfg.run;
            pingpong_pkg::addr_bounds: begin
                prdata[pingpong_pkg::bounds_min_lsb +: pingpong_pkg::count_w] = cfg.min_val;
                prdata[pingpong_pkg::bounds_max_lsb +: pingpong_pkg::count_w] = cfg.max_val;
            end
            pingpong_pkg::addr_prescale:
                prdata[pingpong_pkg::prescale_w-1:0] = cfg.prescale;
            pingpong_pkg::addr_status:
                prdata[pingpong_pkg::count_w:0] = {cfg.direction, cfg.count};
            default:
                addr_hit = 1'b0;
        endcase
    end

    assign pslverr = psel & penable & ~addr_hit;

endmodule

`default_nettype wire

// File: rtl/button_pulse.sv
`timescale 1ns/1ns
`default_nettype none

module button_pulse (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic btn,
    output logic      pulse
);

    logic [pingpong_pkg::debounce_len-1:0] hist;
    logic                                  pressed;
    logic                                  pressed_q;

    assign pressed = &hist;  // Held high for the whole window

    always_ff @(posedge clk) begin
        if (rst_n) begin
            hist      <= '0;
            pressed_q <= 1'b0;
        end else begin
            hist      <= {hist[pingpong_pkg::debounce_len-2:0], btn};
            pressed_q <= pressed;
        end
    end

    // Rising edge of the debounced level only
    assign pulse = pressed & ~pressed_q;

endmodule

`default_nettype wire

// File: rtl/ping_pong_counter.sv
`timescale 1ns/1ns
`default_nettype none

module ping_pong_counter (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic flip_req,
    ctr_if.counter    cfg
);

    logic [pingpong_pkg::prescale_w-1:0] pre_cnt;
    logic                                tick;
    logic                                flip_pend;
    logic                                flip_eff;
    logic                                in_range;
    logic                                eff_dir;
    logic                                next_dir;
    logic [pingpong_pkg::count_w-1:0]    next_count;

    assign tick     = cfg.run && (pre_cnt >= cfg.prescale);
    assign flip_eff = flip_pend | flip_req;  // A pulse in the tick cycle counts too

    assign in_range = (cfg.max_val > cfg.min_val)
                      && (cfg.count >= cfg.min_val)
                      && (cfg.count <= cfg.max_val);

    // Flip first, then the normal bounce rule in the new direction.
    // This keeps a flip at a bound from leaving the range.
    always_comb begin
        eff_dir = cfg.direction ^ flip_eff;
        if (eff_dir) begin
            if (cfg.count < cfg.max_val) begin
                next_dir   = 1'b1;
                next_count = cfg.count + 1'b1;
            end else begin
                next_dir   = 1'b0;  // Turn at max
                next_count = cfg.count - 1'b1;
            end
        end else begin
            if (cfg.count > cfg.min_val) begin
                next_dir   = 1'b0;
                next_count = cfg.count - 1'b1;
            end else begin
                next_dir   = 1'b1;
                next_count = cfg.count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pre_cnt       <= '0;
            flip_pend     <= 1'b0;
            cfg.count     <= '0;
            cfg.direction <= 1'b1;
        end else if (cfg.restart) begin
            pre_cnt       <= '0;
            flip_pend     <= 1'b0;
            cfg.count     <= cfg.min_val;
            cfg.direction <= 1'b1;
        end else begin
            if (!cfg.run || tick)
                pre_cnt <= '0;
            else
                pre_cnt <= pre_cnt + 1'b1;

            if (tick && in_range) begin
                cfg.count     <= next_count;
                cfg.direction <= next_dir;
                flip_pend     <= 1'b0;  // Consumed by this step
            end else if (flip_req) begin
                flip_pend <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/seven_seg_scan.sv
`timescale 1ns/1ns
`default_nettype none

module seven_seg_scan (
    input  wire logic          clk,
    input  wire logic          rst_n,
    ctr_if.display             cfg,
    output logic [3:0]         an,
    output pingpong_pkg::seg_t seg
);

    logic [$clog2(pingpong_pkg::scan_div)-1:0] scan_cnt;
    logic                                      scan_wrap;
    logic [1:0]                                sel_q;
    logic [1:0]                                sel_next;
    logic [pingpong_pkg::count_w-1:0]          ones;
    logic                                      tens;
    pingpong_pkg::seg_t                        dir_glyph;
    pingpong_pkg::seg_t                        seg_next;

    assign scan_wrap = (scan_cnt == $bits(scan_cnt)'(pingpong_pkg::scan_div - 1));
    assign sel_next  = scan_wrap ? sel_q + 2'd1 : sel_q;

    // Count is at most 15, so tens is 0 or 1
    assign tens = (cfg.count >= 4'd10);
    assign ones = tens ? cfg.count - 4'd10 : cfg.count;

    assign dir_glyph = cfg.direction ? pingpong_pkg::glyph_up : pingpong_pkg::glyph_down;

    always_comb begin
        case (sel_next)
            2'd0:    seg_next = pingpong_pkg::digit_glyph[ones];
            2'd1:    seg_next = pingpong_pkg::digit_glyph[{3'd0, tens}];
            default: seg_next = dir_glyph;  // Both direction digits
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            scan_cnt <= '0;
            sel_q    <= 2'd0;
            an       <= 4'b1110;  // Ones digit first
        end else begin
            scan_cnt <= scan_wrap ? '0 : scan_cnt + 1'b1;
            sel_q    <= sel_next;
            an       <= ~(4'b0001 << sel_next);
        end
    end

    // Refreshed every clock so a new count shows one clock later
    always_ff @(posedge clk) begin
        seg <= seg_next;
    end

endmodule

`default_nettype wire

// File: rtl/ping_pong_top.sv
`timescale 1ns/1ns
`default_nettype none

module ping_pong_top (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             btn,
    input  wire logic                             psel,
    input  wire logic                             penable,
    input  wire logic                             pwrite,
    input  wire logic [7:0]                       paddr,
    input  wire logic [31:0]                      pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic [3:0]                            an,
    output pingpong_pkg::seg_t                    seg,
    output logic [pingpong_pkg::count_w-1:0]      count,
    output logic                                  direction
);

    logic flip_req;

    ctr_if u_ctr_if ();

    apb_ctrl_regs u_apb_ctrl_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (u_ctr_if.regs)
    );

    button_pulse u_button_pulse (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (btn),
        .pulse (flip_req)
    );

    ping_pong_counter u_ping_pong_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .flip_req (flip_req),
        .cfg      (u_ctr_if.counter)
    );

    seven_seg_scan u_seven_seg_scan (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (u_ctr_if.display),
        .an    (an),
        .seg   (seg)
    );

    // Exported for observation
    assign count     = u_ctr_if.count;
    assign direction = u_ctr_if.direction;

endmodule

`default_nettype wire

// File: test/ping_pong_props.sv
`timescale 1ns/1ns
`default_nettype none

module ping_pong_props (
    input wire logic                         clk,
    input wire logic                         rst_n,
    input wire logic                         run,
    input wire logic                         restart,
    input wire logic [pingpong_pkg::count_w-1:0] min_val,
    input wire logic [pingpong_pkg::count_w-1:0] max_val,
    input wire logic [pingpong_pkg::count_w-1:0] count
);

    // Valid bounds with count inside keep it inside
    a_in_range: assert property (@(posedge clk) disable iff (rst_n)
        (!restart && max_val > min_val && count >= min_val && count <= max_val)
        |=> (count >= $past(min_val) && count <= $past(max_val)))
        else $error("count left the valid bounds");

    a_frozen: assert property (@(posedge clk) disable iff (rst_n)
        (!run && !restart) |=> (count == $past(count)))
        else $error("count moved while run was low");

    a_unit_step: assert property (@(posedge clk) disable iff (rst_n)
        !restart |=> (count == $past(count) || count == $past(count) + 4'd1
                      || count == $past(count) - 4'd1))
        else $error("count stepped by more than one");

endmodule

bind ping_pong_counter ping_pong_props u_ping_pong_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (cfg.run),
    .restart (cfg.restart),
    .min_val (cfg.min_val),
    .max_val (cfg.max_val),
    .count   (cfg.count)
);

`default_nettype wire

// File: test/ping_pong_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ping_pong_checker (
    input wire logic               clk,
    input wire logic               rst_n,
    input wire logic               btn,
    input wire logic               psel,
    input wire logic               penable,
    input wire logic               pwrite,
    input wire logic [7:0]         paddr,
    input wire logic [31:0]        pwdata,
    input wire logic [3:0]         count,
    input wire logic               direction,
    input wire logic [3:0]         an,
    input wire pingpong_pkg::seg_t seg
);

    int         errors = 0;
    logic [3:0] an_seen = 4'b0000;
    logic       m_run, m_restart, m_dir, m_pend, prev_dir;
    logic [3:0] m_min, m_max, m_count, prev_count;
    int         m_prescale, m_wait, high_run, high_run_q;

    // Returns {direction, count} after one step; a flip turns first, bounds turn after
    function automatic logic [4:0] step_to(logic [3:0] c, logic up, logic flip,
                                           logic [3:0] lo, logic [3:0] hi);
        logic go_up;
        go_up = up ^ flip;
        if (go_up && c == hi)
            go_up = 1'b0;
        else if (!go_up && c == lo)
            go_up = 1'b1;
        return {go_up, go_up ? c + 4'd1 : c - 4'd1};
    endfunction

    always @(posedge clk) begin
        logic       pulse;
        logic       wr;
        logic [4:0] nxt;
        prev_count = m_count;
        prev_dir   = m_dir;
        if (rst_n) begin
            m_run      = 0;
            m_restart  = 0;
            m_min      = 0;
            m_max      = 15;
            m_prescale = 0;
            m_count    = 0;
            m_dir      = 1;
            m_pend     = 0;
            m_wait     = 0;
            high_run   = 0;
            high_run_q = 0;
        end else begin
            pulse = (high_run == pingpong_pkg::debounce_len)
                    && (high_run_q != pingpong_pkg::debounce_len);
            wr = psel && penable && pwrite;
            if (m_restart) begin
                m_count = m_min;
                m_dir   = 1'b1;
                m_wait  = 0;
                m_pend  = 1'b0;
            end else if (m_run && m_wait >= m_prescale) begin  // Step tick
                m_wait = 0;
                if (m_max > m_min && m_count >= m_min && m_count <= m_max) begin
                    nxt     = step_to(m_count, m_dir, m_pend | pulse, m_min, m_max);
                    m_count = nxt[3:0];
                    m_dir   = nxt[4];
                    m_pend  = 1'b0;
                end else if (pulse) begin
                    m_pend = 1'b1;
                end
            end else begin
                m_wait = m_run ? m_wait + 1 : 0;
                if (pulse)
                    m_pend = 1'b1;
            end
            m_restart = wr && paddr == pingpong_pkg::addr_ctrl
                        && pwdata[pingpong_pkg::ctrl_restart_bit];
            if (wr && paddr == pingpong_pkg::addr_ctrl)
                m_run = pwdata[pingpong_pkg::ctrl_run_bit];
            if (wr && paddr == pingpong_pkg::addr_bounds) begin
                m_min = pwdata[pingpong_pkg::bounds_min_lsb +: 4];
                m_max = pwdata[pingpong_pkg::bounds_max_lsb +: 4];
            end
            if (wr && paddr == pingpong_pkg::addr_prescale)
                m_prescale = pwdata[15:0];
            high_run_q = high_run;
            if (!btn)
                high_run = 0;
            else if (high_run < pingpong_pkg::debounce_len)
                high_run = high_run + 1;
        end
    end

    always @(negedge clk) begin
        pingpong_pkg::seg_t exp_seg;
        if (!rst_n) begin
            if (count !== m_count || direction !== m_dir) begin
                errors++;
                $display("ERROR %0t: count %0d dir %0b, expected count %0d dir %0b",
                         $time, count, direction, m_count, m_dir);
            end
            exp_seg = seg;
            case (an)
                4'b1110: exp_seg = pingpong_pkg::digit_glyph[prev_count % 10];
                4'b1101: exp_seg = pingpong_pkg::digit_glyph[prev_count / 10];
                4'b1011, 4'b0111:
                    exp_seg = prev_dir ? pingpong_pkg::glyph_up : pingpong_pkg::glyph_down;
                default: begin
                    errors++;
                    $display("ERROR %0t: digit select %b is not one active-low digit", $time, an);
                end
            endcase
            if (seg !== exp_seg) begin
                errors++;
                $display("ERROR %0t: seg %b on an %b, expected %b", $time, seg, an, exp_seg);
            end
            an_seen = an_seen | ~an;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_ping_pong.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ping_pong;

    localparam int apb_timeout = 20;

    typedef struct packed {
        int min_v, max_v, prescale, run, restart, clocks, press_a, press_b, short_hold;
    } row_t;

    // min max prescale run restart clocks press_a press_b short
    row_t rows [9] = '{
        '{2, 9, 0, 1, 1, 30, -1, -1, 0},    // Bounce 2..9
        '{2, 9, 3, 1, 1, 40, -1, -1, 0},    // One step every 4 clocks
        '{2, 9, 3, 0, 0, 20, -1, -1, 0},    // Frozen
        '{0, 15, 30, 1, 1, 70, 40, -1, 0},  // Flip once clear of min
        '{0, 15, 30, 1, 1, 70, 40, -1, 1},  // Short hold, no flip
        '{0, 15, 30, 1, 1, 70, 34, 48, 0},  // Two presses merge
        '{9, 4, 2, 1, 0, 30, -1, -1, 0},    // max below min
        '{12, 15, 2, 1, 0, 30, -1, -1, 0},  // Bounds exclude count
        '{12, 15, 0, 1, 1, 30, -1, -1, 0}   // Restart to min, passes 13
    };

    logic               clk, rst_n, btn, psel, penable, pwrite;
    logic [7:0]         paddr;
    logic [31:0]        pwdata, prdata;
    logic               pready, pslverr, direction;
    logic [3:0]         an, count;
    pingpong_pkg::seg_t seg;
    int                 tb_errors = 0;
    logic [15:0]        lfsr_state = 16'd5;

    ping_pong_top u_ping_pong_top (
        .clk(clk), .rst_n(rst_n), .btn(btn), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .an(an), .seg(seg),
        .count(count), .direction(direction)
    );

    ping_pong_checker u_checker (
        .clk(clk), .rst_n(rst_n), .btn(btn), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .count(count), .direction(direction), .an(an), .seg(seg)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic expect_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            tb_errors++;
            $display("ERROR %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // Setup phase, then access phase until pready
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            if (waits >= apb_timeout)
                abort_run("Timed out waiting for pready");
            @(negedge clk);
            #1;
            waits++;
        end
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, wdata, rdata, err);
        expect_value("pslverr on write", {31'd0, err}, 32'd0);
    endtask

    task automatic run_row(input row_t r);
        int hold_left;
        int extra;
        hold_left = 0;
        apb_write(pingpong_pkg::addr_bounds, (r.max_v << 8) | r.min_v);
        apb_write(pingpong_pkg::addr_prescale, r.prescale);
        apb_write(pingpong_pkg::addr_ctrl, (r.restart << 1) | r.run);
        for (int cyc = 0; cyc < r.clocks; cyc++) begin
            @(negedge clk);
            if (cyc == r.press_a || cyc == r.press_b) begin
                if (r.short_hold)
                    hold_left = pingpong_pkg::debounce_len - 1;
                else begin
                    take_bits(3, extra);  // Hold of debounce_len..debounce_len+7
                    hold_left = pingpong_pkg::debounce_len + extra;
                end
            end
            btn = (hold_left > 0);
            if (hold_left > 0)
                hold_left--;
        end
        @(negedge clk);
        btn = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        rst_n = 1'b1;
        btn = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;

        apb_transfer(1'b0, pingpong_pkg::addr_status, 0, rdata, err);
        expect_value("STATUS after reset", rdata, 32'h10);
        apb_write(pingpong_pkg::addr_bounds, 32'h0903);
        apb_transfer(1'b0, pingpong_pkg::addr_bounds, 0, rdata, err);
        expect_value("BOUNDS", rdata, 32'h0903);
        apb_write(pingpong_pkg::addr_prescale, 32'h1234);
        apb_transfer(1'b0, pingpong_pkg::addr_prescale, 0, rdata, err);
        expect_value("PRESCALE", rdata, 32'h1234);
        apb_transfer(1'b0, 8'h10, 0, rdata, err);
        expect_value("pslverr at 0x10", {31'd0, err}, 32'd1);
        expect_value("data at 0x10", rdata, 32'd0);

        foreach (rows[i])
            run_row(rows[i]);

        if (u_checker.an_seen !== 4'b1111) begin
            tb_errors++;
            $display("The digit select did not reach all four digits");
        end
        $display("Done: %0d testbench errors, %0d checker errors", tb_errors, u_checker.errors);
        if (tb_errors + u_checker.errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/pingpong_pkg.sv
rtl/ctr_if.sv
rtl/apb_ctrl_regs.sv
rtl/button_pulse.sv
rtl/ping_pong_counter.sv
rtl/seven_seg_scan.sv
rtl/ping_pong_top.sv
test/ping_pong_props.sv
test/ping_pong_checker.sv
test/tb_ping_pong.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ping_pong
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
